//--- source/acq_wr_pkg.sv
package acq_wr_pkg;

    // record tags found in the top nibble of each fifo word
    typedef enum logic [3:0] {
        TAG_FILL = 4'd1,
        TAG_WFM  = 4'd2,
        TAG_CKSM = 4'd4
    } rec_tag_e;

    // field widths of the command and config words
    // these bound the largest ADDR_W and CNT_W a top level may choose
    localparam int CMD_CNT_W  = 32;
    localparam int CMD_ADDR_W = 29;
    // burst count width in the fill summary
    localparam int SUM_CNT_W  = 24;

    // apb register map
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;
    localparam logic [APB_AW-1:0] REG_CTRL   = 8'h00;
    localparam logic [APB_AW-1:0] REG_START  = 8'h04;
    localparam logic [APB_AW-1:0] REG_STATUS = 8'h08;

    // fill header payload, only the start address is used here
    typedef struct packed {
        logic [51:0] upper;
        logic [22:0] start_addr;
        logic [52:0] lower;
    } fill_hdr_t;

    // waveform header payload, burst count in the low bits
    typedef struct packed {
        logic [104:0] info;
        logic [22:0]  num_bursts;
    } wfm_hdr_t;

    // same 128 bits read as either header, selected by the tag
    typedef union packed {
        fill_hdr_t fill;
        wfm_hdr_t  wfm;
    } rec_payload_u;

    // fifo head word
    typedef struct packed {
        rec_tag_e     tag;
        rec_payload_u payload;
    } fifo_word_t;

    // written to the header fifo once per fill
    typedef struct packed {
        logic [SUM_CNT_W-1:0] total_bursts;
        fill_hdr_t            hdr;
    } fill_summary_t;

    // sequencer to issuers
    typedef struct packed {
        logic                  load;
        logic [CMD_CNT_W-1:0]  count;
        logic                  active;
        logic                  load_addr;
        logic [CMD_ADDR_W-1:0] start_addr;
    } issue_cmd_t;

    // software configuration
    typedef struct packed {
        logic                  acq_enabled;
        logic                  en_fixed_start;
        logic [CMD_ADDR_W-1:0] fixed_start_addr;
    } wr_cfg_t;

endpackage

//--- source/wr_cfg_apb.sv
`timescale 1ns/1ps

module wr_cfg_apb (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [acq_wr_pkg::APB_AW-1:0] paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [acq_wr_pkg::APB_DW-1:0] pwdata,
    output logic [acq_wr_pkg::APB_DW-1:0] prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic                          sync_err,
    input  logic                          wr_done,
    output acq_wr_pkg::wr_cfg_t           cfg
);
    import acq_wr_pkg::*;

    logic access;
    logic addr_hit;

    // second cycle of a transfer, no wait states
    assign access  = psel && penable;
    assign pready  = 1'b1;
    // unmapped offsets flag an error on the access cycle
    assign pslverr = access && !addr_hit;

    // read mux, status bits come straight from the sequencer
    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            REG_CTRL: begin
                prdata[0] = cfg.acq_enabled;
                prdata[1] = cfg.en_fixed_start;
            end
            REG_START: begin
                prdata[CMD_ADDR_W-1:0] = cfg.fixed_start_addr;
            end
            REG_STATUS: begin
                prdata[0] = sync_err;
                prdata[1] = wr_done;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    // register writes land on the access cycle
    // status offset ignores writes
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (access && pwrite) begin
            case (paddr)
                REG_CTRL: begin
                    cfg.acq_enabled    <= pwdata[0];
                    cfg.en_fixed_start <= pwdata[1];
                end
                REG_START: begin
                    cfg.fixed_start_addr <= pwdata[CMD_ADDR_W-1:0];
                end
                default: ;
            endcase
        end
    end

endmodule

//--- source/address_issuer.sv
`timescale 1ns/1ps

module address_issuer #(
    parameter int ADDR_W = 23,
    parameter int CNT_W  = 24
) (
    input  logic                   clk,
    input  logic                   reset,
    input  acq_wr_pkg::issue_cmd_t cmd,
    input  logic                   data_accept,
    input  logic                   app_rdy,
    output logic                   app_en,
    output logic [ADDR_W+2:0]      app_addr,
    output logic                   addr_accept,
    output logic                   addr_done
);

    logic [ADDR_W-1:0] addr_gen;
    logic [CNT_W-1:0]  addr_cnt;
    // data beats accepted minus addresses accepted
    logic [CNT_W-1:0]  lead;

    assign addr_accept = app_en && app_rdy;
    assign addr_done   = (addr_cnt == '0);
    // an address only goes out once its data beat is already in
    assign app_en      = cmd.active && (lead != '0) && !addr_done;
    // memory takes a byte-lane address, low three bits are zero
    assign app_addr    = {addr_gen, 3'b000};

    // word address generator
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_gen <= '0;
        end else if (cmd.load_addr) begin
            addr_gen <= cmd.start_addr[ADDR_W-1:0];
        end else if (addr_accept) begin
            addr_gen <= addr_gen + 1'b1;
        end
    end

    // addresses still owed for this record
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_cnt <= '0;
        end else if (cmd.load) begin
            addr_cnt <= cmd.count[CNT_W-1:0];
        end else if (addr_accept) begin
            addr_cnt <= addr_cnt - 1'b1;
        end
    end

    // throttle, both accepted in one cycle leaves it unchanged
    always_ff @(posedge clk) begin
        if (reset) begin
            lead <= '0;
        end else if (data_accept && !addr_accept) begin
            lead <= lead + 1'b1;
        end else if (addr_accept && !data_accept) begin
            lead <= lead - 1'b1;
        end
    end

endmodule

//--- source/data_issuer.sv
`timescale 1ns/1ps

module data_issuer #(
    parameter int CNT_W = 24
) (
    input  logic                   clk,
    input  logic                   reset,
    input  acq_wr_pkg::issue_cmd_t cmd,
    input  logic                   fifo_empty,
    input  logic                   app_wdf_rdy,
    output logic                   app_wdf_wren,
    output logic                   app_wdf_end,
    output logic                   fifo_rd_en,
    output logic                   data_accept,
    output logic                   data_done
);

    // bursts still owed for this record
    logic [CNT_W-1:0] burst_cnt;

    assign data_done    = (burst_cnt == '0);
    // present a beat only with data at the fifo head
    assign app_wdf_wren = cmd.active && !fifo_empty && !data_done;
    // single beat bursts, every beat is also the last
    assign app_wdf_end  = app_wdf_wren;
    assign data_accept  = app_wdf_wren && app_wdf_rdy;
    // fall-through fifo, pop once the beat is taken
    assign fifo_rd_en   = data_accept;

    always_ff @(posedge clk) begin
        if (reset) begin
            burst_cnt <= '0;
        end else if (cmd.load) begin
            burst_cnt <= cmd.count[CNT_W-1:0];
        end else if (data_accept) begin
            burst_cnt <= burst_cnt - 1'b1;
        end
    end

endmodule

//--- source/wr_sequencer.sv
`timescale 1ns/1ps

module wr_sequencer #(
    parameter int ADDR_W = 23,
    parameter int CNT_W  = 24
) (
    input  logic                      clk,
    input  logic                      reset,
    input  acq_wr_pkg::wr_cfg_t       cfg,
    input  acq_wr_pkg::fifo_word_t    fifo_dat,
    input  logic                      fifo_empty,
    input  logic                      addr_done,
    input  logic                      data_done,
    input  logic                      addr_accept,
    input  logic                      acq_done,
    output acq_wr_pkg::issue_cmd_t    cmd,
    output logic                      hdr_wr_en,
    output acq_wr_pkg::fill_summary_t hdr_wr_dat,
    output logic                      sync_err,
    output logic                      wr_done
);
    import acq_wr_pkg::*;

    // one-hot state bit indices
    localparam int IDLE       = 0;
    localparam int TEST_TAG   = 1;
    localparam int SYNC_ERR   = 2;
    localparam int INIT_FILL  = 3;
    localparam int INIT_WFM   = 4;
    localparam int INIT_CKSM  = 5;
    localparam int WRITE      = 6;
    localparam int WRITE_CKSM = 7;
    localparam int WRITE_HDR  = 8;
    localparam int DONE       = 9;
    localparam int NUM_STATES = 10;

    logic [NUM_STATES-1:0] state;
    logic [NUM_STATES-1:0] next;
    logic                  acq_done_meta;
    logic                  acq_done_sync;
    logic                  rec_done;
    logic                  in_fill;
    logic [CNT_W-1:0]      wfm_count;
    logic [ADDR_W-1:0]     start_addr_d;
    logic [CNT_W-1:0]      total_cnt;
    fill_hdr_t             fill_hdr_q;
    logic [SUM_CNT_W-1:0]  sum_cnt_q;
    logic                  cmd_load;
    logic                  cmd_active;
    logic                  cmd_load_addr;
    logic [CMD_CNT_W-1:0]  cmd_count;
    logic [CMD_ADDR_W-1:0] cmd_start_addr;

    // record finished once both countdowns hit zero
    assign rec_done     = addr_done && data_done;
    // waveform header plus its data bursts
    assign wfm_count    = CNT_W'(fifo_dat.payload.wfm.num_bursts) + CNT_W'(1);
    // fixed register overrides the header start address
    assign start_addr_d = cfg.en_fixed_start ? ADDR_W'(cfg.fixed_start_addr)
                                             : ADDR_W'(fifo_dat.payload.fill.start_addr);

    assign cmd = '{load: cmd_load, count: cmd_count, active: cmd_active,
                   load_addr: cmd_load_addr, start_addr: cmd_start_addr};
    assign hdr_wr_dat = '{total_bursts: sum_cnt_q, hdr: fill_hdr_q};

    // two-flop synchronizer on acq_done
    always_ff @(posedge clk) begin
        if (reset) begin
            acq_done_meta <= 1'b0;
            acq_done_sync <= 1'b0;
        end else begin
            acq_done_meta <= acq_done;
            acq_done_sync <= acq_done_meta;
        end
    end

    always_comb begin
        next = '0;
        case (1'b1)
            state[IDLE]: begin
                // fall-through fifo, head word valid when not empty
                if (fifo_empty) next[IDLE] = 1'b1;
                else next[TEST_TAG] = 1'b1;
            end
            state[TEST_TAG]: begin
                case (fifo_dat.tag)
                    TAG_FILL: next[INIT_FILL] = 1'b1;
                    TAG_WFM:  next[INIT_WFM]  = 1'b1;
                    TAG_CKSM: next[INIT_CKSM] = 1'b1;
                    // lost record alignment
                    default:  next[SYNC_ERR]  = 1'b1;
                endcase
            end
            // only leaves when acquisition is disabled
            state[SYNC_ERR]: next[SYNC_ERR] = 1'b1;
            state[INIT_FILL], state[INIT_WFM]: next[WRITE] = 1'b1;
            state[INIT_CKSM]: next[WRITE_CKSM] = 1'b1;
            state[WRITE]: begin
                if (rec_done) next[IDLE] = 1'b1;
                else next[WRITE] = 1'b1;
            end
            state[WRITE_CKSM]: begin
                if (rec_done) next[WRITE_HDR] = 1'b1;
                else next[WRITE_CKSM] = 1'b1;
            end
            state[WRITE_HDR]: next[DONE] = 1'b1;
            state[DONE]: begin
                if (acq_done_sync) next[IDLE] = 1'b1;
                else next[DONE] = 1'b1;
            end
            default: next[IDLE] = 1'b1;
        endcase
    end

    // state and control outputs, registered from the next state
    // disabling acquisition forces idle with all strobes low
    always_ff @(posedge clk) begin
        if (reset || !cfg.acq_enabled) begin
            state         <= NUM_STATES'(1) << IDLE;
            cmd_load      <= 1'b0;
            cmd_load_addr <= 1'b0;
            cmd_active    <= 1'b0;
            hdr_wr_en     <= 1'b0;
            sync_err      <= 1'b0;
            wr_done       <= 1'b0;
        end else begin
            state         <= next;
            cmd_load      <= next[INIT_FILL] || next[INIT_WFM] || next[INIT_CKSM];
            cmd_load_addr <= next[INIT_FILL];
            cmd_active    <= next[WRITE] || next[WRITE_CKSM];
            hdr_wr_en     <= next[WRITE_HDR];
            sync_err      <= next[SYNC_ERR];
            wr_done       <= next[DONE];
        end
    end

    // fill header burst is counted up front, then every later address
    always_ff @(posedge clk) begin
        if (reset) begin
            total_cnt <= '0;
            in_fill   <= 1'b0;
        end else if (state[INIT_FILL]) begin
            total_cnt <= CNT_W'(1);
            in_fill   <= 1'b1;
        end else begin
            if (state[INIT_WFM] || state[INIT_CKSM]) in_fill <= 1'b0;
            if (addr_accept && !in_fill) total_cnt <= total_cnt + 1'b1;
        end
    end

    // counts and header sampled while the tag is under test
    always_ff @(posedge clk) begin
        if (state[TEST_TAG]) begin
            cmd_count      <= (fifo_dat.tag == TAG_WFM) ? CMD_CNT_W'(wfm_count)
                                                        : CMD_CNT_W'(1);
            cmd_start_addr <= CMD_ADDR_W'(start_addr_d);
        end
        if (state[TEST_TAG] && fifo_dat.tag == TAG_FILL) begin
            fill_hdr_q <= fifo_dat.payload.fill;
        end
        // total frozen as the checksum completes
        if (state[WRITE_CKSM] && rec_done) begin
            sum_cnt_q <= SUM_CNT_W'(total_cnt);
        end
    end

endmodule

//--- source/acq_wr_top.sv
`timescale 1ns/1ps

module acq_wr_top #(
    parameter int ADDR_W = 23,
    parameter int CNT_W  = 24
) (
    input  logic                          clk,
    input  logic                          reset,
    // apb configuration slave
    input  logic [acq_wr_pkg::APB_AW-1:0] paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [acq_wr_pkg::APB_DW-1:0] pwdata,
    output logic [acq_wr_pkg::APB_DW-1:0] prdata,
    output logic                          pready,
    output logic                          pslverr,
    // adc sample fifo head
    input  acq_wr_pkg::fifo_word_t        fifo_dat,
    input  logic                          fifo_empty,
    output logic                          fifo_rd_en,
    // memory write data channel
    output logic                          app_wdf_wren,
    output logic                          app_wdf_end,
    input  logic                          app_wdf_rdy,
    // memory address channel
    output logic                          app_en,
    output logic [ADDR_W+2:0]             app_addr,
    input  logic                          app_rdy,
    // header fifo
    output logic                          hdr_wr_en,
    output acq_wr_pkg::fill_summary_t     hdr_wr_dat,
    input  logic                          acq_done
);
    import acq_wr_pkg::*;

    wr_cfg_t    cfg;
    issue_cmd_t cmd;
    logic       sync_err;
    logic       wr_done;
    logic       addr_done;
    logic       data_done;
    logic       addr_accept;
    logic       data_accept;

    wr_cfg_apb u_cfg (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .sync_err, .wr_done, .cfg
    );

    wr_sequencer #(.ADDR_W(ADDR_W), .CNT_W(CNT_W)) u_seq (
        .clk, .reset, .cfg, .fifo_dat, .fifo_empty, .addr_done, .data_done,
        .addr_accept, .acq_done, .cmd, .hdr_wr_en, .hdr_wr_dat, .sync_err, .wr_done
    );

    // address side follows the data side through data_accept
    address_issuer #(.ADDR_W(ADDR_W), .CNT_W(CNT_W)) u_addr (
        .clk, .reset, .cmd, .data_accept, .app_rdy,
        .app_en, .app_addr, .addr_accept, .addr_done
    );

    data_issuer #(.CNT_W(CNT_W)) u_data (
        .clk, .reset, .cmd, .fifo_empty, .app_wdf_rdy,
        .app_wdf_wren, .app_wdf_end, .fifo_rd_en, .data_accept, .data_done
    );

endmodule

//--- test/acq_wr_properties.sv
`timescale 1ns/1ps

module acq_wr_properties #(
    parameter int ADDR_W = 23
) (
    input logic              clk,
    input logic              reset,
    input logic              acq_enabled,
    input logic              app_en,
    input logic              app_rdy,
    input logic [ADDR_W+2:0] app_addr,
    input logic              app_wdf_wren,
    input logic              app_wdf_end,
    input logic              app_wdf_rdy,
    input logic              fifo_rd_en,
    input logic              hdr_wr_en,
    input logic              sync_err,
    input logic              wr_done
);

    // count of failed assertions
    int fail_cnt = 0;
    // running totals of accepted addresses and data beats
    int unsigned addr_total;
    int unsigned data_total;

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_total <= 0;
            data_total <= 0;
        end else begin
            addr_total <= addr_total + (app_en && app_rdy);
            data_total <= data_total + (app_wdf_wren && app_wdf_rdy);
        end
    end

    // every control output low right after a reset cycle
    a_reset_low: assert property (@(posedge clk)
        reset |=> !app_en && !app_wdf_wren && !fifo_rd_en && !hdr_wr_en && !sync_err && !wr_done)
        else begin
            $error("control output high after reset");
            fail_cnt++;
        end

    // an address goes out only once its data beat was already taken
    a_throttle: assert property (@(posedge clk) disable iff (reset)
        addr_total + (app_en && app_rdy) <= data_total)
        else begin
            $error("address accepted ahead of its data beat");
            fail_cnt++;
        end

    // pop only with a beat the memory takes
    a_pop: assert property (@(posedge clk) disable iff (reset)
        fifo_rd_en |-> app_wdf_wren && app_wdf_rdy)
        else begin
            $error("fifo popped without an accepted beat");
            fail_cnt++;
        end

    // single beat bursts
    a_wdf_end: assert property (@(posedge clk) disable iff (reset)
        app_wdf_end == app_wdf_wren)
        else begin
            $error("app_wdf_end differs from app_wdf_wren");
            fail_cnt++;
        end

    // address held while the controller stalls
    a_addr_hold: assert property (@(posedge clk) disable iff (reset || !acq_enabled)
        app_en && !app_rdy |=> app_en && $stable(app_addr))
        else begin
            $error("address dropped or changed while app_rdy low");
            fail_cnt++;
        end

    // one cycle header pulse with wr_done right behind it
    a_hdr_pulse: assert property (@(posedge clk) disable iff (reset || !acq_enabled)
        hdr_wr_en |=> !hdr_wr_en && wr_done)
        else begin
            $error("header write not a single pulse followed by wr_done");
            fail_cnt++;
        end

    // no memory traffic once record alignment is lost
    a_sync_quiet: assert property (@(posedge clk) disable iff (reset)
        sync_err |-> !app_en && !app_wdf_wren)
        else begin
            $error("memory write during sync error");
            fail_cnt++;
        end

endmodule

//--- test/tb_acq_wr.sv
`timescale 1ns/1ps

module tb_acq_wr;
    import acq_wr_pkg::*;

    localparam int ADDR_W     = 23;
    localparam int CNT_W      = 24;
    localparam int WAIT_LIMIT = 2000;

    logic              clk;
    logic              reset;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    fifo_word_t        fifo_dat;
    logic              fifo_empty;
    logic              fifo_rd_en;
    logic              app_wdf_wren;
    logic              app_wdf_end;
    logic              app_wdf_rdy;
    logic              app_en;
    logic [ADDR_W+2:0] app_addr;
    logic              app_rdy;
    logic              hdr_wr_en;
    fill_summary_t     hdr_wr_dat;
    logic              acq_done;

    // fifo model contents with the head word at index 0
    fifo_word_t        fifo_q[$];
    logic [15:0]       lfsr;
    logic              pop_pend;
    logic              stall;
    int                errors;
    int                addr_seen;
    int                beats_seen;
    int                hdr_seen;
    logic [ADDR_W-1:0] exp_addr;
    fill_hdr_t         exp_hdr;
    int                exp_total;

    acq_wr_top #(.ADDR_W(ADDR_W), .CNT_W(CNT_W)) DUT (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .pslverr, .fifo_dat, .fifo_empty, .fifo_rd_en, .app_wdf_wren, .app_wdf_end,
        .app_wdf_rdy, .app_en, .app_addr, .app_rdy, .hdr_wr_en, .hdr_wr_dat, .acq_done
    );

    bind acq_wr_top acq_wr_properties #(.ADDR_W(ADDR_W)) u_props (
        .clk(clk), .reset(reset), .acq_enabled(cfg.acq_enabled), .app_en(app_en),
        .app_rdy(app_rdy), .app_addr(app_addr), .app_wdf_wren(app_wdf_wren),
        .app_wdf_end(app_wdf_end), .app_wdf_rdy(app_wdf_rdy), .fifo_rd_en(fifo_rd_en),
        .hdr_wr_en(hdr_wr_en), .sync_err(sync_err), .wr_done(wr_done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic fifo_word_t make_word(input rec_tag_e tag, input logic [127:0] bits);
        fifo_word_t w;
        w.tag     = tag;
        w.payload = bits;
        return w;
    endfunction

    task automatic end_run();
        int assert_errs;
        assert_errs = DUT.u_props.fail_cnt;
        $display("errors: %0d check, %0d assertion", errors, assert_errs);
        if (errors == 0 && assert_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        $display("timeout waiting for %s at %0t ns", what, $time);
        errors++;
        end_run();
    endtask

    task automatic check_val(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // setup then access with read data and pslverr sampled mid access cycle
    task automatic apb_xfer(input logic write, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata,
                            output logic [APB_DW-1:0] rdata, output logic err);
        int n;
        n       = 0;
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (pready !== 1'b1) begin
            if (n == 16) begin
                give_up("APB pready");
            end else begin
                @(negedge clk);
                n++;
            end
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             input logic exp_err);
        logic [APB_DW-1:0] rd;
        logic              err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_val("pslverr", err, exp_err);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] exp,
                            input logic exp_err);
        logic [APB_DW-1:0] rd;
        logic              err;
        apb_xfer(1'b0, addr, '0, rd, err);
        check_val("pslverr", err, exp_err);
        if (!exp_err) check_val("prdata", rd, exp);
    endtask

    // poll status until the two flags match
    task automatic wait_status(input logic [1:0] want, input string what);
        logic [APB_DW-1:0] rd;
        logic              err;
        int                n;
        n = 0;
        apb_xfer(1'b0, REG_STATUS, '0, rd, err);
        while (rd[1:0] !== want) begin
            if (n == 200) begin
                give_up(what);
            end else begin
                apb_xfer(1'b0, REG_STATUS, '0, rd, err);
                n++;
            end
        end
    endtask

    // returns just after a rising edge so the caller can drive at once
    task automatic wait_hdr(input int count);
        int n;
        n = 0;
        while (hdr_seen < count) begin
            if (n == WAIT_LIMIT) begin
                give_up("header FIFO write");
            end else begin
                @(posedge clk);
                #1;
                n++;
            end
        end
    endtask

    // one fill of header, waveforms of 3 and 5 bursts and checksum
    task automatic run_fill(input logic [ADDR_W-1:0] hdr_start,
                            input logic [ADDR_W-1:0] exp_start);
        fill_hdr_t hdr;
        int        lens[2];
        int        base;
        lens           = '{3, 5};
        hdr.upper      = 52'h9_8765_4321_ABCD;
        hdr.start_addr = hdr_start;
        hdr.lower      = 53'h1F_0F0F_0F0F_0F0F ^ 53'(hdr_start);
        exp_hdr        = hdr;
        exp_addr       = exp_start;
        exp_total      = 1 + (lens[0] + 1) + (lens[1] + 1) + 1;
        addr_seen      = 0;
        beats_seen     = 0;
        base           = hdr_seen;
        fifo_q.push_back(make_word(TAG_FILL, hdr));
        foreach (lens[k]) begin
            fifo_q.push_back(make_word(TAG_WFM, {105'h5A + 105'(k), 23'(lens[k])}));
            for (int j = 0; j < lens[k]; j++) begin
                fifo_q.push_back(make_word(rec_tag_e'(4'h0), {4{32'hDA7A_0000 + 32'(j)}}));
            end
        end
        fifo_q.push_back(make_word(TAG_CKSM, {4{32'hC5C5_0000 + 32'(hdr_start)}}));
        wait_hdr(base + 1);
        // wr_done up and held while acq_done stays low
        apb_read(REG_STATUS, 32'h2, 1'b0);
        repeat (6) @(posedge clk);
        #1;
        apb_read(REG_STATUS, 32'h2, 1'b0);
        check_val("addresses vs beats", addr_seen, beats_seen);
        check_val("beats per fill", beats_seen, exp_total);
        check_val("fifo model depth", fifo_q.size(), 0);
        acq_done = 1'b1;
        @(posedge clk);
        #1;
        acq_done = 1'b0;
        wait_status(2'b00, "wr_done to clear after acq_done");
        check_val("hdr_wr_en pulses", hdr_seen, base + 1);
    endtask

    // fifo head and memory ready model
    // pop sampled at the falling edge, new values driven just after the rising edge
    always begin
        @(negedge clk);
        pop_pend = (fifo_rd_en === 1'b1);
        @(posedge clk);
        #1;
        if (pop_pend) begin
            if (fifo_q.size() == 0) begin
                $display("fifo popped while the model queue was empty at %0t ns", $time);
                errors++;
            end else begin
                void'(fifo_q.pop_front());
            end
        end
        lfsr        = lfsr_step(lfsr);
        app_rdy     = lfsr[0];
        lfsr        = lfsr_step(lfsr);
        app_wdf_rdy = lfsr[0];
        // head goes empty for a cycle now and then
        lfsr        = lfsr_step(lfsr);
        stall       = lfsr[0];
        lfsr        = lfsr_step(lfsr);
        stall       = stall & lfsr[0];
        fifo_empty  = (fifo_q.size() == 0) || stall;
        fifo_dat    = (fifo_q.size() != 0) ? fifo_q[0] : '0;
    end

    // scoreboard on accepted transfers
    always @(negedge clk) begin
        if (reset === 1'b0) begin
            if (app_en === 1'b1 && app_rdy === 1'b1) begin
                check_val("app_addr", app_addr, {exp_addr, 3'b000});
                exp_addr = exp_addr + 1'b1;
                addr_seen++;
            end
            if (app_wdf_wren === 1'b1 && app_wdf_rdy === 1'b1) beats_seen++;
            if (hdr_wr_en === 1'b1) begin
                hdr_seen++;
                check_val("hdr_wr_dat.hdr", hdr_wr_dat.hdr, exp_hdr);
                check_val("hdr_wr_dat.total_bursts", hdr_wr_dat.total_bursts, exp_total);
            end
        end
    end

    initial begin
        repeat (40000) @(posedge clk);
        give_up("end of test within the global cycle limit");
    end

    initial begin
        reset       = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        fifo_dat    = '0;
        fifo_empty  = 1'b1;
        app_rdy     = 1'b0;
        app_wdf_rdy = 1'b0;
        acq_done    = 1'b0;
        lfsr        = 16'd44381;
        errors      = 0;
        addr_seen   = 0;
        beats_seen  = 0;
        hdr_seen    = 0;
        exp_addr    = '0;
        exp_hdr     = '0;
        exp_total   = 0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // register readback and unmapped offsets
        apb_read(REG_STATUS, 32'h0, 1'b0);
        apb_write(REG_CTRL, 32'h2, 1'b0);
        apb_read(REG_CTRL, 32'h2, 1'b0);
        apb_write(REG_START, 32'h002A_5A00, 1'b0);
        apb_read(REG_START, 32'h002A_5A00, 1'b0);
        apb_read(8'h0C, 32'h0, 1'b1);
        apb_write(8'h10, 32'hFFFF_FFFF, 1'b1);
        apb_write(REG_CTRL, 32'h1, 1'b0);
        apb_read(REG_CTRL, 32'h1, 1'b0);

        // start address from the fill header, then from the fixed register
        run_fill(23'h01_2340, 23'h01_2340);
        apb_write(REG_CTRL, 32'h3, 1'b0);
        run_fill(23'h7F_0000, 23'h2A_5A00);
        apb_write(REG_CTRL, 32'h1, 1'b0);

        // bad tag stops the sequencer with no memory traffic
        addr_seen  = 0;
        beats_seen = 0;
        fifo_q.push_back(make_word(rec_tag_e'(4'd7), {4{32'hBAD0_0007}}));
        wait_status(2'b01, "sync_err in status");
        repeat (4) @(posedge clk);
        #1;
        apb_read(REG_STATUS, 32'h1, 1'b0);
        check_val("beats during sync error", beats_seen, 0);
        check_val("addresses during sync error", addr_seen, 0);
        fifo_q.delete();
        apb_write(REG_CTRL, 32'h0, 1'b0);
        wait_status(2'b00, "sync_err to clear");
        apb_write(REG_CTRL, 32'h1, 1'b0);
        run_fill(23'h00_0777, 23'h00_0777);

        end_run();
    end

endmodule

//--- acq_wr.f
source/acq_wr_pkg.sv
source/wr_cfg_apb.sv
source/address_issuer.sv
source/data_issuer.sv
source/wr_sequencer.sv
source/acq_wr_top.sv
test/acq_wr_properties.sv
test/tb_acq_wr.sv

//--- Bender.yml
package:
  name: acq_wr

sources:
  - source/acq_wr_pkg.sv
  - source/wr_cfg_apb.sv
  - source/address_issuer.sv
  - source/data_issuer.sv
  - source/wr_sequencer.sv
  - source/acq_wr_top.sv
  - target: test
    files:
      - test/acq_wr_properties.sv
      - test/tb_acq_wr.sv
